// ==== common/eic_settings.svh ====
`ifndef EIC_SETTINGS_SVH
`define EIC_SETTINGS_SVH

// interrupt lines handled by the controller
`define EIC_NUM_IRQS     4

// flops per line in the input synchronizer
`define EIC_SYNC_STAGES  2

// word indices on wb_addr_i[1:0]
`define EIC_REG_IDR      0
`define EIC_REG_IER      1
`define EIC_REG_IMR      2
`define EIC_REG_ISR      3

`endif

// ==== common/eic_pkg.sv ====
`default_nettype none

`include "eic_settings.svh"

package eic_pkg;

   // how a line turns into an event
   typedef enum logic [1:0] {
      IRQ_RISING   = 2'd0,
      IRQ_FALLING  = 2'd1,
      IRQ_LEVEL_LO = 2'd2,
      IRQ_LEVEL_HI = 2'd3
   } irq_mode_e;

   // one bit per interrupt line
   typedef logic [`EIC_NUM_IRQS-1:0] irq_vec_t;

   typedef irq_mode_e irq_mode_tab_t [`EIC_NUM_IRQS];

   // fixed trigger per line, index 0 first
   localparam irq_mode_tab_t IRQ_MODES = '{
      IRQ_RISING,
      IRQ_FALLING,
      IRQ_LEVEL_LO,
      IRQ_LEVEL_HI
   };

   // level a line rests at when it is not requesting
   function automatic logic irq_idle_level(irq_mode_e mode);
      return (mode == IRQ_FALLING) || (mode == IRQ_LEVEL_LO);
   endfunction

endpackage

`default_nettype wire

// ==== common/wb_regs_pkg.sv ====
`default_nettype none

`include "eic_settings.svh"

package wb_regs_pkg;

   localparam int unsigned WB_DATA_W = 32;

   typedef logic [WB_DATA_W-1:0] wb_word_t;

   // register select, straight from the word address
   typedef enum logic [1:0] {
      REG_IDR = 2'(`EIC_REG_IDR),
      REG_IER = 2'(`EIC_REG_IER),
      REG_IMR = 2'(`EIC_REG_IMR),
      REG_ISR = 2'(`EIC_REG_ISR)
   } eic_reg_e;

endpackage

`default_nettype wire

// ==== common/eic_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface eic_ctrl_if import eic_pkg::*; ();

   // single cycle write strobes from the bus side
   logic     ier_wr;
   logic     idr_wr;
   logic     isr_wr;
   irq_vec_t wr_bits;   // low data bits of the write

   // register state back toward the bus
   irq_vec_t imr;
   irq_vec_t isr;

   modport regs_mp (
      output ier_wr,
      output idr_wr,
      output isr_wr,
      output wr_bits,
      input  imr,
      input  isr
   );

   modport status_mp (
      input  ier_wr,
      input  idr_wr,
      input  isr_wr,
      input  wr_bits,
      output imr,
      output isr
   );

endinterface

`default_nettype wire

// ==== eic/irq_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eic_settings.svh"

module irq_detector import eic_pkg::*; (
   input  logic     wb_clk_i,
   input  logic     rst_n_i,
   input  irq_vec_t irq_lines_i,
   output irq_vec_t events_o
);

   localparam int unsigned NSYNC = `EIC_SYNC_STAGES;

   irq_vec_t idle_lvl;
   irq_vec_t sync_q [NSYNC];
   irq_vec_t cur_q;     // synchronized level
   irq_vec_t prv_q;     // previous level, for edges
   irq_vec_t event_d;
   irq_vec_t event_q;

   always_comb begin
      for (int i = 0; i < `EIC_NUM_IRQS; i++) begin
         idle_lvl[i] = irq_idle_level(IRQ_MODES[i]);
      end
   end

   // history starts at the resting level so reset gives no edge
   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         for (int s = 0; s < NSYNC; s++) begin
            sync_q[s] <= idle_lvl;
         end
         cur_q <= idle_lvl;
         prv_q <= idle_lvl;
      end else begin
         sync_q[0] <= irq_lines_i;
         for (int s = 1; s < NSYNC; s++) begin
            sync_q[s] <= sync_q[s-1];
         end
         cur_q <= sync_q[NSYNC-1];
         prv_q <= cur_q;
      end
   end

   always_comb begin
      for (int i = 0; i < `EIC_NUM_IRQS; i++) begin
         case (IRQ_MODES[i])
            IRQ_RISING:   event_d[i] = cur_q[i] & ~prv_q[i];
            IRQ_FALLING:  event_d[i] = ~cur_q[i] & prv_q[i];
            IRQ_LEVEL_LO: event_d[i] = ~cur_q[i];
            default:      event_d[i] = cur_q[i];   // level high
         endcase
      end
   end

   // registered so edge and level paths leave together
   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         event_q <= '0;
      end else begin
         event_q <= event_d;
      end
   end

   assign events_o = event_q;

endmodule

`default_nettype wire

// ==== eic/irq_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_status import eic_pkg::*; (
   input  logic     wb_clk_i,
   input  logic     rst_n_i,
   input  irq_vec_t events_i,
   eic_ctrl_if.status_mp ctrl,
   output logic     irq_o
);

   irq_vec_t imr_q;
   irq_vec_t imr_d;
   irq_vec_t isr_q;
   irq_vec_t isr_d;
   logic     irq_q;

   always_comb begin
      imr_d = imr_q;
      if (ctrl.ier_wr) begin
         imr_d = imr_d | ctrl.wr_bits;
      end
      if (ctrl.idr_wr) begin
         imr_d = imr_d & ~ctrl.wr_bits;
      end
   end

   // clear first, then set, so a live source wins over the ack
   always_comb begin
      isr_d = isr_q;
      if (ctrl.isr_wr) begin
         isr_d = isr_d & ~ctrl.wr_bits;
      end
      isr_d = isr_d | (events_i & imr_q);
   end

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         imr_q <= '0;
         isr_q <= '0;
         irq_q <= 1'b0;
      end else begin
         imr_q <= imr_d;
         isr_q <= isr_d;
         irq_q <= |isr_d;   // tracks pending bits on the same edge
      end
   end

   assign ctrl.imr = imr_q;
   assign ctrl.isr = isr_q;
   assign irq_o    = irq_q;

endmodule

`default_nettype wire

// ==== eic/eic_wb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eic_settings.svh"

module eic_wb_regs import wb_regs_pkg::*; (
   input  logic       wb_clk_i,
   input  logic       rst_n_i,
   input  logic [1:0] wb_addr_i,
   input  wb_word_t   wb_data_i,
   output wb_word_t   wb_data_o,
   input  logic       wb_cyc_i,
   input  logic       wb_stb_i,
   input  logic       wb_we_i,
   output logic       wb_ack_o,
   eic_ctrl_if.regs_mp ctrl
);

   eic_reg_e reg_sel;
   logic     access;
   logic     ack_q;
   wb_word_t rdata_d;
   wb_word_t rdata_q;

   assign reg_sel = eic_reg_e'(wb_addr_i);

   // request seen and not yet acknowledged
   assign access = wb_cyc_i & wb_stb_i & ~ack_q;

   // ack is one cycle, then a gap of one before the next
   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   assign wb_ack_o = ack_q;

   // strobes land on the edge where ack rises
   always_comb begin
      ctrl.ier_wr = 1'b0;
      ctrl.idr_wr = 1'b0;
      ctrl.isr_wr = 1'b0;
      if (access && wb_we_i) begin
         case (reg_sel)
            REG_IER: ctrl.ier_wr = 1'b1;
            REG_IDR: ctrl.idr_wr = 1'b1;
            REG_ISR: ctrl.isr_wr = 1'b1;
            default: ;   // imr is read-only
         endcase
      end
   end

   assign ctrl.wr_bits = wb_data_i[`EIC_NUM_IRQS-1:0];

   always_comb begin
      case (reg_sel)
         REG_IMR: rdata_d = wb_word_t'(ctrl.imr);
         REG_ISR: rdata_d = wb_word_t'(ctrl.isr);
         default: rdata_d = '0;   // idr and ier read back zero
      endcase
   end

   // captured with the ack, valid while ack is high
   always_ff @(posedge wb_clk_i) begin
      if (access && !wb_we_i) begin
         rdata_q <= rdata_d;
      end
   end

   assign wb_data_o = rdata_q;

endmodule

`default_nettype wire

// ==== hw/wb_test_interrupts.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_test_interrupts import eic_pkg::*, wb_regs_pkg::*; (
   input  logic       rst_n_i,
   input  logic       wb_clk_i,
   input  logic [1:0] wb_addr_i,
   input  wb_word_t   wb_data_i,
   output wb_word_t   wb_data_o,
   input  logic       wb_cyc_i,
   input  logic [3:0] wb_sel_i,   // full words only
   input  logic       wb_stb_i,
   input  logic       wb_we_i,
   output logic       wb_ack_o,
   output logic       wb_irq_o,
   input  logic       irq_ipe_i,
   input  logic       irq_ine_i,
   input  logic       irq_il0_i,
   input  logic       irq_il1_i
);

   irq_vec_t irq_lines;
   irq_vec_t events;

   // bit order follows the mode table
   assign irq_lines = {irq_il1_i, irq_il0_i, irq_ine_i, irq_ipe_i};

   eic_ctrl_if ctrl_if ();

   irq_detector i_detector (
      .wb_clk_i    (wb_clk_i),
      .rst_n_i     (rst_n_i),
      .irq_lines_i (irq_lines),
      .events_o    (events)
   );

   irq_status i_status (
      .wb_clk_i (wb_clk_i),
      .rst_n_i  (rst_n_i),
      .events_i (events),
      .ctrl     (ctrl_if.status_mp),
      .irq_o    (wb_irq_o)
   );

   eic_wb_regs i_regs (
      .wb_clk_i  (wb_clk_i),
      .rst_n_i   (rst_n_i),
      .wb_addr_i (wb_addr_i),
      .wb_data_i (wb_data_i),
      .wb_data_o (wb_data_o),
      .wb_cyc_i  (wb_cyc_i),
      .wb_stb_i  (wb_stb_i),
      .wb_we_i   (wb_we_i),
      .wb_ack_o  (wb_ack_o),
      .ctrl      (ctrl_if.regs_mp)
   );

endmodule

`default_nettype wire

// ==== bench/tb_wb_test_interrupts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eic_settings.svh"

module tb_wb_test_interrupts import wb_regs_pkg::*; ();

   localparam int unsigned CLK_PERIOD  = 100;   // ns
   localparam int unsigned ACK_TIMEOUT = 16;
   localparam int unsigned IRQ_TIMEOUT = 20;

   localparam logic [1:0] LINE_IPE = 2'd0;   // rising edge
   localparam logic [1:0] LINE_INE = 2'd1;   // falling edge
   localparam logic [1:0] LINE_IL0 = 2'd2;   // level low
   localparam logic [1:0] LINE_IL1 = 2'd3;   // level high

   typedef enum logic [3:0] {
      ACT_WRITE,
      ACT_READ,
      ACT_LINE,
      ACT_WAIT_IRQ,
      ACT_NO_IRQ,
      ACT_IRQ_IS,
      ACT_IDLE,
      ACT_ACK_LOWEST
   } act_e;

   // sel is a register word index or a line number, depending on act
   typedef struct packed {
      act_e       act;
      logic [1:0] sel;
      wb_word_t   value;
      wb_word_t   exp_val;
   } row_t;

   logic       clk;
   logic       rst_n;
   logic [1:0] wb_addr;
   wb_word_t   wb_wdata;
   wb_word_t   wb_rdata;
   logic       wb_cyc;
   logic [3:0] wb_sel;
   logic       wb_stb;
   logic       wb_we;
   logic       wb_ack;
   logic       wb_irq;
   logic       irq_ipe;
   logic       irq_ine;
   logic       irq_il0;
   logic       irq_il1;

   row_t rows [$];

   wb_test_interrupts i_dut (
      .rst_n_i   (rst_n),
      .wb_clk_i  (clk),
      .wb_addr_i (wb_addr),
      .wb_data_i (wb_wdata),
      .wb_data_o (wb_rdata),
      .wb_cyc_i  (wb_cyc),
      .wb_sel_i  (wb_sel),
      .wb_stb_i  (wb_stb),
      .wb_we_i   (wb_we),
      .wb_ack_o  (wb_ack),
      .wb_irq_o  (wb_irq),
      .irq_ipe_i (irq_ipe),
      .irq_ine_i (irq_ine),
      .irq_il0_i (irq_il0),
      .irq_il1_i (irq_il1)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic compare_values(input wb_word_t actual, input wb_word_t expected,
                                 input string what);
      if (actual !== expected) begin
         abort_run($sformatf("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                             $time, what, actual, expected));
      end
   endtask

   // outputs are looked at on the falling edge, away from the driving edge
   task automatic wait_for_ack(input string what);
      int unsigned waited;
      waited = 0;
      @(negedge clk);
      while (!wb_ack) begin
         if (waited == ACK_TIMEOUT) begin
            abort_run($sformatf("the bus %s at %0t ns never got an ack", what, $time));
         end
         waited++;
         @(negedge clk);
      end
   endtask

   task automatic end_cycle();
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      @(negedge clk);
      compare_values(wb_word_t'(wb_ack), '0, "ack lasts one cycle");
   endtask

   task automatic bus_write(input logic [1:0] addr, input wb_word_t data);
      @(posedge clk);
      wb_addr  <= addr;
      wb_wdata <= data;
      wb_sel   <= 4'hf;
      wb_we    <= 1'b1;
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wait_for_ack("write");
      end_cycle();
   endtask

   task automatic bus_read(input logic [1:0] addr, output wb_word_t data);
      @(posedge clk);
      wb_addr <= addr;
      wb_sel  <= 4'hf;
      wb_we   <= 1'b0;
      wb_cyc  <= 1'b1;
      wb_stb  <= 1'b1;
      wait_for_ack("read");
      data = wb_rdata;   // valid while ack is high
      end_cycle();
   endtask

   task automatic drive_line(input logic [1:0] idx, input logic level);
      @(posedge clk);
      case (idx)
         LINE_IPE: irq_ipe <= level;
         LINE_INE: irq_ine <= level;
         LINE_IL0: irq_il0 <= level;
         default:  irq_il1 <= level;
      endcase
   endtask

   task automatic wait_irq_high();
      int unsigned waited;
      waited = 0;
      @(negedge clk);
      while (!wb_irq) begin
         if (waited == IRQ_TIMEOUT) begin
            abort_run($sformatf("irq_o did not rise within %0d cycles", IRQ_TIMEOUT));
         end
         waited++;
         @(negedge clk);
      end
   endtask

   task automatic watch_irq_low();
      repeat (IRQ_TIMEOUT) begin
         @(negedge clk);
         compare_values(wb_word_t'(wb_irq), '0, "irq_o stays low");
      end
   endtask

   // software picks the lowest pending source and clears only that one
   task automatic ack_lowest_pending(input wb_word_t expected);
      wb_word_t isr;
      wb_word_t low;
      bus_read(`EIC_REG_ISR, isr);
      low = '0;
      for (int i = `EIC_NUM_IRQS - 1; i >= 0; i--) begin
         if (isr[i]) begin
            low = wb_word_t'(1) << i;
         end
      end
      if (low == '0) begin
         abort_run("no pending bit found to acknowledge");
      end
      compare_values(low, expected, "lowest pending bit");
      bus_write(`EIC_REG_ISR, low);
   endtask

   task automatic apply_row(input row_t r);
      wb_word_t data;
      case (r.act)
         ACT_WRITE: bus_write(r.sel, r.value);
         ACT_READ: begin
            bus_read(r.sel, data);
            compare_values(data, r.exp_val, $sformatf("read of register %0d", r.sel));
         end
         ACT_LINE:       drive_line(r.sel, r.value[0]);
         ACT_WAIT_IRQ:   wait_irq_high();
         ACT_NO_IRQ:     watch_irq_low();
         ACT_IRQ_IS: begin
            @(negedge clk);
            compare_values(wb_word_t'(wb_irq), r.exp_val, "irq_o level");
         end
         ACT_IDLE:       repeat (r.value) @(posedge clk);
         ACT_ACK_LOWEST: ack_lowest_pending(r.exp_val);
         default:        abort_run("the table holds an unknown action");
      endcase
   endtask

   task automatic add_row(input act_e act, input logic [1:0] sel,
                          input wb_word_t value, input wb_word_t exp_val);
      row_t r;
      r.act     = act;
      r.sel     = sel;
      r.value   = value;
      r.exp_val = exp_val;
      rows.push_back(r);
   endtask

   task automatic build_table();
      // state after reset
      add_row(ACT_IRQ_IS, 0, 0, 0);
      add_row(ACT_READ, `EIC_REG_IMR, 0, 32'h0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h0);
      // mask set and clear
      add_row(ACT_WRITE, `EIC_REG_IER, 32'hf, 0);
      add_row(ACT_READ, `EIC_REG_IMR, 0, 32'hf);
      add_row(ACT_WRITE, `EIC_REG_IDR, 32'h5, 0);
      add_row(ACT_READ, `EIC_REG_IMR, 0, 32'ha);
      add_row(ACT_READ, `EIC_REG_IDR, 0, 32'h0);
      add_row(ACT_READ, `EIC_REG_IER, 0, 32'h0);
      // edge sources
      add_row(ACT_WRITE, `EIC_REG_IER, 32'hf, 0);
      add_row(ACT_READ, `EIC_REG_IMR, 0, 32'hf);
      add_row(ACT_LINE, LINE_IPE, 1, 0);
      add_row(ACT_WAIT_IRQ, 0, 0, 0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h1);
      add_row(ACT_WRITE, `EIC_REG_ISR, 32'h1, 0);
      add_row(ACT_IRQ_IS, 0, 0, 0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h0);
      add_row(ACT_LINE, LINE_IPE, 0, 0);
      add_row(ACT_NO_IRQ, 0, 0, 0);
      add_row(ACT_LINE, LINE_INE, 0, 0);
      add_row(ACT_WAIT_IRQ, 0, 0, 0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h2);
      add_row(ACT_WRITE, `EIC_REG_ISR, 32'h2, 0);
      add_row(ACT_IRQ_IS, 0, 0, 0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h0);
      add_row(ACT_LINE, LINE_INE, 1, 0);
      add_row(ACT_NO_IRQ, 0, 0, 0);
      // level low, pends again while held
      add_row(ACT_LINE, LINE_IL0, 0, 0);
      add_row(ACT_WAIT_IRQ, 0, 0, 0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h4);
      add_row(ACT_WRITE, `EIC_REG_ISR, 32'h4, 0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h4);
      add_row(ACT_LINE, LINE_IL0, 1, 0);
      add_row(ACT_IDLE, 0, 8, 0);
      add_row(ACT_WRITE, `EIC_REG_ISR, 32'h4, 0);
      add_row(ACT_NO_IRQ, 0, 0, 0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h0);
      // level high
      add_row(ACT_LINE, LINE_IL1, 1, 0);
      add_row(ACT_WAIT_IRQ, 0, 0, 0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h8);
      add_row(ACT_WRITE, `EIC_REG_ISR, 32'h8, 0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h8);
      add_row(ACT_LINE, LINE_IL1, 0, 0);
      add_row(ACT_IDLE, 0, 8, 0);
      add_row(ACT_WRITE, `EIC_REG_ISR, 32'h8, 0);
      add_row(ACT_NO_IRQ, 0, 0, 0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h0);
      // everything masked
      add_row(ACT_WRITE, `EIC_REG_IDR, 32'hf, 0);
      add_row(ACT_READ, `EIC_REG_IMR, 0, 32'h0);
      add_row(ACT_LINE, LINE_IPE, 1, 0);
      add_row(ACT_LINE, LINE_INE, 0, 0);
      add_row(ACT_LINE, LINE_IL0, 0, 0);
      add_row(ACT_LINE, LINE_IL1, 1, 0);
      add_row(ACT_NO_IRQ, 0, 0, 0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h0);
      add_row(ACT_LINE, LINE_IPE, 0, 0);
      add_row(ACT_LINE, LINE_INE, 1, 0);
      add_row(ACT_LINE, LINE_IL0, 1, 0);
      add_row(ACT_LINE, LINE_IL1, 0, 0);
      add_row(ACT_NO_IRQ, 0, 0, 0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h0);
      // two sources at once, lowest first
      add_row(ACT_WRITE, `EIC_REG_IER, 32'hf, 0);
      add_row(ACT_LINE, LINE_IPE, 1, 0);
      add_row(ACT_LINE, LINE_INE, 0, 0);
      add_row(ACT_WAIT_IRQ, 0, 0, 0);
      add_row(ACT_IDLE, 0, 6, 0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h3);
      add_row(ACT_ACK_LOWEST, 0, 0, 32'h1);
      add_row(ACT_IRQ_IS, 0, 0, 1);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h2);
      add_row(ACT_ACK_LOWEST, 0, 0, 32'h2);
      add_row(ACT_IRQ_IS, 0, 0, 0);
      add_row(ACT_READ, `EIC_REG_ISR, 0, 32'h0);
      add_row(ACT_LINE, LINE_IPE, 0, 0);
      add_row(ACT_LINE, LINE_INE, 1, 0);
      add_row(ACT_NO_IRQ, 0, 0, 0);
   endtask

   initial begin
      void'($urandom(32'hfdb2_c247));
      rst_n    = 1'b0;
      wb_addr  = '0;
      wb_wdata = '0;
      wb_cyc   = 1'b0;
      wb_sel   = 4'h0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      irq_ipe  = 1'b0;   // lines start at their resting level
      irq_ine  = 1'b1;
      irq_il0  = 1'b1;
      irq_il1  = 1'b0;
      build_table();
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      foreach (rows[n]) begin
         apply_row(rows[n]);
         repeat ($urandom_range(0, 3)) @(posedge clk);
      end
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/eic_pkg.sv
common/wb_regs_pkg.sv
common/eic_ctrl_if.sv
eic/irq_detector.sv
eic/irq_status.sv
eic/eic_wb_regs.sv
hw/wb_test_interrupts.sv
bench/tb_wb_test_interrupts.sv

// ==== Bender.yml ====
package:
  name: wb_test_interrupts

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/eic_pkg.sv
      - common/wb_regs_pkg.sv
      - common/eic_ctrl_if.sv
      - eic/irq_detector.sv
      - eic/irq_status.sv
      - eic/eic_wb_regs.sv
      - hw/wb_test_interrupts.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - bench/tb_wb_test_interrupts.sv
